/* src/surf4_pkg.sv */
package surf4_pkg;

   // Control bus widths.
   localparam int WB_DAT_W = 32;
   localparam int WB_ADR_W = 20;
   localparam int WB_SEL_W = 4;

   // Region code sits in the top nibble of the byte address.
   localparam int WB_RGN_W = 4;

   // Master request, held stable until ack.
   typedef struct packed {
      logic                cyc;
      logic                stb;
      logic                we;
      logic [WB_ADR_W-1:0] adr;
      logic [WB_DAT_W-1:0] dat;
      logic [WB_SEL_W-1:0] sel;
   } wbc_req_t;

   // Slave response, ack is a single-cycle pulse.
   typedef struct packed {
      logic                ack;
      logic [WB_DAT_W-1:0] dat;
   } wbc_rsp_t;

   // Decoded target of the current request.
   typedef enum logic [1:0] {
      SLV_ID_CTRL,
      SLV_HK,
      SLV_HKBUF,
      SLV_NONE
   } wbc_slave_e;

   // Owner of the shared bus.
   typedef enum logic {
      MST_HOST,
      MST_HK
   } wbc_master_e;

   // Housekeeping master states.
   typedef enum logic {
      HK_IDLE,
      HK_WRITE
   } hk_state_e;

   // Address map, region codes in bits 19:16.
   localparam logic [WB_RGN_W-1:0] SLV_BASE_ID_CTRL = 4'h0;
   localparam logic [WB_RGN_W-1:0] SLV_BASE_HK      = 4'h1;
   localparam logic [WB_RGN_W-1:0] SLV_BASE_HKBUF   = 4'h2;

   // ID and control block offsets.
   localparam logic [3:0] REG_ID      = 4'h0;
   localparam logic [3:0] REG_VERSION = 4'h4;
   localparam logic [3:0] REG_CTRL    = 4'h8;
   localparam logic [3:0] REG_SCRATCH = 4'hC;

   // Collector slave offsets.
   localparam logic [3:0] REG_HK_COUNT  = 4'h0;
   localparam logic [3:0] REG_HK_ENABLE = 4'h4;

   // Byte-lane merge of a write into an existing word.
   function automatic logic [WB_DAT_W-1:0] wbc_byte_merge(
      input logic [WB_DAT_W-1:0] old_dat,
      input logic [WB_DAT_W-1:0] new_dat,
      input logic [WB_SEL_W-1:0] sel
   );
      logic [WB_DAT_W-1:0] merged;
      merged = old_dat;
      for (int b = 0; b < WB_SEL_W; b++) begin
         if (sel[b]) begin
            merged[b*8 +: 8] = new_dat[b*8 +: 8];
         end
      end
      return merged;
   endfunction

endpackage

/* src/wbc_intercon.sv */
`timescale 1ns/1ps

module wbc_intercon import surf4_pkg::*; (
   input  logic     wbc_clk_i,
   input  logic     rst_n_i,
   input  wbc_req_t host_req_i,
   input  wbc_req_t hk_req_i,
   output wbc_rsp_t host_rsp_o,
   output wbc_rsp_t hk_rsp_o,
   output wbc_req_t id_req_o,
   output wbc_req_t hksl_req_o,
   output wbc_req_t hkbuf_req_o,
   input  wbc_rsp_t id_rsp_i,
   input  wbc_rsp_t hksl_rsp_i,
   input  wbc_rsp_t hkbuf_rsp_i
);

   // Owner register doubles as the last owner for round robin.
   wbc_master_e owner_q;
   wbc_master_e next_owner;
   logic        busy_q;
   logic        owner_cyc;
   wbc_req_t    bus_req;
   wbc_rsp_t    bus_rsp;
   wbc_slave_e  slave_sel;
   logic        none_ack_q;

   assign owner_cyc = (owner_q == MST_HOST) ? host_req_i.cyc : hk_req_i.cyc;

   // Round robin pick, the other master wins a tie.
   always_comb begin
      next_owner = owner_q;
      if (host_req_i.cyc && hk_req_i.cyc) begin
         next_owner = (owner_q == MST_HOST) ? MST_HK : MST_HOST;
      end else if (host_req_i.cyc) begin
         next_owner = MST_HOST;
      end else if (hk_req_i.cyc) begin
         next_owner = MST_HK;
      end
   end

   // Grant moves only once the owner has dropped cyc.
   always_ff @(posedge wbc_clk_i) begin
      if (!rst_n_i) begin
         owner_q <= MST_HOST;
         busy_q  <= 1'b0;
      end else if (!busy_q || !owner_cyc) begin
         owner_q <= next_owner;
         busy_q  <= host_req_i.cyc || hk_req_i.cyc;
      end
   end

   // Only the granted request reaches the decoder.
   always_comb begin
      bus_req = '0;
      if (busy_q) begin
         bus_req = (owner_q == MST_HOST) ? host_req_i : hk_req_i;
      end
   end

   // Region decode on address bits 19:16.
   always_comb begin
      case (bus_req.adr[WB_ADR_W-1 -: WB_RGN_W])
         SLV_BASE_ID_CTRL: slave_sel = SLV_ID_CTRL;
         SLV_BASE_HK:      slave_sel = SLV_HK;
         SLV_BASE_HKBUF:   slave_sel = SLV_HKBUF;
         default:          slave_sel = SLV_NONE;
      endcase
   end

   // Shared request, stb reaches the selected slave only.
   always_comb begin
      id_req_o        = bus_req;
      id_req_o.stb    = bus_req.stb && (slave_sel == SLV_ID_CTRL);
      hksl_req_o      = bus_req;
      hksl_req_o.stb  = bus_req.stb && (slave_sel == SLV_HK);
      hkbuf_req_o     = bus_req;
      hkbuf_req_o.stb = bus_req.stb && (slave_sel == SLV_HKBUF);
   end

   // Unmapped regions get a local ack, writes are dropped.
   always_ff @(posedge wbc_clk_i) begin
      if (!rst_n_i) begin
         none_ack_q <= 1'b0;
      end else begin
         none_ack_q <= bus_req.cyc && bus_req.stb && (slave_sel == SLV_NONE) && !none_ack_q;
      end
   end

   // Response mux.
   always_comb begin
      case (slave_sel)
         SLV_ID_CTRL: bus_rsp = id_rsp_i;
         SLV_HK:      bus_rsp = hksl_rsp_i;
         SLV_HKBUF:   bus_rsp = hkbuf_rsp_i;
         default: begin
            bus_rsp.ack = none_ack_q;
            bus_rsp.dat = '0;
         end
      endcase
   end

   // The waiting master sees no ack.
   always_comb begin
      host_rsp_o = '0;
      hk_rsp_o   = '0;
      if (busy_q) begin
         if (owner_q == MST_HOST) begin
            host_rsp_o = bus_rsp;
         end else begin
            hk_rsp_o = bus_rsp;
         end
      end
   end

endmodule

/* src/surf4_id_ctrl.sv */
`timescale 1ns/1ps

module surf4_id_ctrl import surf4_pkg::*; #(
   parameter logic [WB_DAT_W-1:0] BOARD_ID   = 32'h5355_5246,
   parameter logic [WB_DAT_W-1:0] FW_VERSION = 32'h0004_0001
) (
   input  logic       wbc_clk_i,
   input  logic       rst_n_i,
   input  wbc_req_t   req_i,
   output wbc_rsp_t   rsp_o,
   output logic       ice40_reset_o,
   output logic [3:0] led_o
);

   // Implemented control bits: LEDs in 7:4, ICE40 reset in 0.
   localparam logic [WB_DAT_W-1:0] CTRL_MASK = 32'h0000_00F1;

   logic                access;
   logic                wr_en;
   logic [3:0]          reg_ofs;
   logic [WB_DAT_W-1:0] ctrl_q;
   logic [WB_DAT_W-1:0] scratch_q;
   logic [WB_DAT_W-1:0] rd_dat;
   logic [WB_DAT_W-1:0] dat_q;
   logic                ack_q;

   // One access per stb, the ack cycle is not a new one.
   assign access  = req_i.cyc && req_i.stb && !ack_q;
   assign wr_en   = access && req_i.we;
   assign reg_ofs = {req_i.adr[3:2], 2'b00};

   always_ff @(posedge wbc_clk_i) begin
      if (!rst_n_i) begin
         ack_q  <= 1'b0;
         ctrl_q <= 32'h0000_0001;
      end else begin
         ack_q <= access;
         if (wr_en && (reg_ofs == REG_CTRL)) begin
            ctrl_q <= wbc_byte_merge(ctrl_q, req_i.dat, req_i.sel) & CTRL_MASK;
         end
      end
   end

   // Scratch holds any value.
   always_ff @(posedge wbc_clk_i) begin
      if (wr_en && (reg_ofs == REG_SCRATCH)) begin
         scratch_q <= wbc_byte_merge(scratch_q, req_i.dat, req_i.sel);
      end
   end

   // Read mux, ID and version are constants.
   always_comb begin
      case (reg_ofs)
         REG_ID:      rd_dat = BOARD_ID;
         REG_VERSION: rd_dat = FW_VERSION;
         REG_CTRL:    rd_dat = ctrl_q;
         default:     rd_dat = scratch_q;
      endcase
   end

   // Registered read data.
   always_ff @(posedge wbc_clk_i) begin
      if (access) begin
         dat_q <= rd_dat;
      end
   end

   assign rsp_o         = '{ack: ack_q, dat: dat_q};
   assign ice40_reset_o = ctrl_q[0];
   assign led_o         = ctrl_q[7:4];

endmodule

/* src/surf4_hk_collector.sv */
`timescale 1ns/1ps

module surf4_hk_collector import surf4_pkg::*; #(
   parameter int HK_DEPTH = 16
) (
   input  logic     wbc_clk_i,
   input  logic     rst_n_i,
   input  wbc_req_t req_i,
   output wbc_rsp_t rsp_o,
   output wbc_req_t mst_req_o,
   input  wbc_rsp_t mst_rsp_i,
   input  logic     pps_i
);

   localparam int CNT_W = 16;
   localparam int IDX_W = $clog2(HK_DEPTH);
   // Zero bits between region code and word index.
   localparam int PAD_W = WB_ADR_W - WB_RGN_W - IDX_W - 2;

   hk_state_e           state_q;
   logic                enable_q;
   logic                pending_q;
   logic                pps_accept;
   logic                start_write;
   logic [CNT_W-1:0]    count_q;
   logic [CNT_W-1:0]    count_next;
   logic [CNT_W-1:0]    rec_cnt_q;
   logic [IDX_W-1:0]    rec_idx_q;
   logic                sl_access;
   logic [3:0]          sl_ofs;
   logic                sl_ack_q;
   logic [WB_DAT_W-1:0] sl_rd_dat;
   logic [WB_DAT_W-1:0] sl_dat_q;

   assign pps_accept  = pps_i && enable_q;
   assign count_next  = pps_accept ? count_q + 1'b1 : count_q;
   // A pending record starts as soon as the master is idle.
   assign start_write = (state_q == HK_IDLE) && (pps_accept || pending_q);

   always_ff @(posedge wbc_clk_i) begin
      if (!rst_n_i) begin
         state_q   <= HK_IDLE;
         pending_q <= 1'b0;
         count_q   <= '0;
      end else begin
         count_q <= count_next;
         // Pulses during a write collapse into one flag.
         if (start_write) begin
            pending_q <= 1'b0;
         end else if (pps_accept) begin
            pending_q <= 1'b1;
         end
         case (state_q)
            HK_IDLE:  if (start_write) state_q <= HK_WRITE;
            HK_WRITE: if (mst_rsp_i.ack) state_q <= HK_IDLE;
            default:  state_q <= HK_IDLE;
         endcase
      end
   end

   // Record captures the count at write start.
   always_ff @(posedge wbc_clk_i) begin
      if (start_write) begin
         rec_cnt_q <= count_next;
         rec_idx_q <= count_next[IDX_W-1:0];
      end
   end

   // Full-word write into the buffer region.
   always_comb begin
      mst_req_o.cyc = (state_q == HK_WRITE);
      mst_req_o.stb = (state_q == HK_WRITE);
      mst_req_o.we  = 1'b1;
      mst_req_o.adr = {SLV_BASE_HKBUF, {PAD_W{1'b0}}, rec_idx_q, 2'b00};
      mst_req_o.dat = {{(WB_DAT_W-CNT_W){1'b0}}, rec_cnt_q};
      mst_req_o.sel = '1;
   end

   // Slave side.
   assign sl_access = req_i.cyc && req_i.stb && !sl_ack_q;
   assign sl_ofs    = {req_i.adr[3:2], 2'b00};

   always_ff @(posedge wbc_clk_i) begin
      if (!rst_n_i) begin
         sl_ack_q <= 1'b0;
         enable_q <= 1'b0;
      end else begin
         sl_ack_q <= sl_access;
         if (sl_access && req_i.we && (sl_ofs == REG_HK_ENABLE) && req_i.sel[0]) begin
            enable_q <= req_i.dat[0];
         end
      end
   end

   // Count is read only.
   always_comb begin
      case (sl_ofs)
         REG_HK_COUNT:  sl_rd_dat = {{(WB_DAT_W-CNT_W){1'b0}}, count_q};
         REG_HK_ENABLE: sl_rd_dat = {{(WB_DAT_W-1){1'b0}}, enable_q};
         default:       sl_rd_dat = '0;
      endcase
   end

   always_ff @(posedge wbc_clk_i) begin
      if (sl_access) begin
         sl_dat_q <= sl_rd_dat;
      end
   end

   assign rsp_o = '{ack: sl_ack_q, dat: sl_dat_q};

endmodule

/* src/hk_buffer.sv */
`timescale 1ns/1ps

module hk_buffer import surf4_pkg::*; #(
   parameter int HK_DEPTH = 16
) (
   input  logic     wbc_clk_i,
   input  logic     rst_n_i,
   input  wbc_req_t req_i,
   output wbc_rsp_t rsp_o
);

   localparam int IDX_W = $clog2(HK_DEPTH);

   logic [WB_DAT_W-1:0] mem_q [HK_DEPTH];
   logic                access;
   logic [IDX_W-1:0]    idx;
   logic                ack_q;
   logic [WB_DAT_W-1:0] dat_q;

   assign access = req_i.cyc && req_i.stb && !ack_q;
   // Word index from the byte address.
   assign idx    = req_i.adr[IDX_W+1:2];

   always_ff @(posedge wbc_clk_i) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Byte-lane writes, registered read.
   always_ff @(posedge wbc_clk_i) begin
      if (access) begin
         if (req_i.we) begin
            mem_q[idx] <= wbc_byte_merge(mem_q[idx], req_i.dat, req_i.sel);
         end
         dat_q <= mem_q[idx];
      end
   end

   assign rsp_o = '{ack: ack_q, dat: dat_q};

endmodule

/* src/surf4_ctrl_top.sv */
`timescale 1ns/1ps

module surf4_ctrl_top import surf4_pkg::*; #(
   parameter logic [WB_DAT_W-1:0] BOARD_ID   = 32'h5355_5246,
   parameter logic [WB_DAT_W-1:0] FW_VERSION = 32'h0004_0001,
   parameter int                  HK_DEPTH   = 16
) (
   input  logic       wbc_clk_i,
   input  logic       rst_n_i,
   input  wbc_req_t   host_req_i,
   output wbc_rsp_t   host_rsp_o,
   input  logic       pps_i,
   output logic       ice40_reset_o,
   output logic [3:0] led_o
);

   // Housekeeping master port.
   wbc_req_t hk_mst_req;
   wbc_rsp_t hk_mst_rsp;
   // Slave ports.
   wbc_req_t id_req;
   wbc_rsp_t id_rsp;
   wbc_req_t hksl_req;
   wbc_rsp_t hksl_rsp;
   wbc_req_t hkbuf_req;
   wbc_rsp_t hkbuf_rsp;

   // Shared control bus with two masters.
   wbc_intercon u_wbc_intercon (
      .wbc_clk_i  (wbc_clk_i),
      .rst_n_i    (rst_n_i),
      .host_req_i (host_req_i),
      .hk_req_i   (hk_mst_req),
      .host_rsp_o (host_rsp_o),
      .hk_rsp_o   (hk_mst_rsp),
      .id_req_o   (id_req),
      .hksl_req_o (hksl_req),
      .hkbuf_req_o(hkbuf_req),
      .id_rsp_i   (id_rsp),
      .hksl_rsp_i (hksl_rsp),
      .hkbuf_rsp_i(hkbuf_rsp)
   );

   // Board ID and control.
   surf4_id_ctrl #(
      .BOARD_ID  (BOARD_ID),
      .FW_VERSION(FW_VERSION)
   ) u_surf4_id_ctrl (
      .wbc_clk_i    (wbc_clk_i),
      .rst_n_i      (rst_n_i),
      .req_i        (id_req),
      .rsp_o        (id_rsp),
      .ice40_reset_o(ice40_reset_o),
      .led_o        (led_o)
   );

   // PPS housekeeping, slave and master.
   surf4_hk_collector #(
      .HK_DEPTH(HK_DEPTH)
   ) u_hk_collector (
      .wbc_clk_i(wbc_clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (hksl_req),
      .rsp_o    (hksl_rsp),
      .mst_req_o(hk_mst_req),
      .mst_rsp_i(hk_mst_rsp),
      .pps_i    (pps_i)
   );

   // Record memory.
   hk_buffer #(
      .HK_DEPTH(HK_DEPTH)
   ) u_hk_buffer (
      .wbc_clk_i(wbc_clk_i),
      .rst_n_i  (rst_n_i),
      .req_i    (hkbuf_req),
      .rsp_o    (hkbuf_rsp)
   );

endmodule

/* verification/surf4_ctrl_checker.sv */
`timescale 1ns/1ps

module surf4_ctrl_checker import surf4_pkg::*; (
   input  logic                wbc_clk_i,
   input  wbc_rsp_t            host_rsp_i,
   input  logic                ice40_reset_i,
   input  logic [3:0]          led_i,
   input  logic                rd_chk_i,
   input  logic [WB_DAT_W-1:0] rd_exp_i,
   input  logic [WB_ADR_W-1:0] rd_adr_i,
   input  logic                out_chk_i,
   input  logic [3:0]          exp_led_i,
   input  logic                exp_ice40_i,
   input  logic                test_start_i,
   input  logic                test_end_i,
   input  logic [8*24-1:0]     test_name_i,
   input  logic                fault_i,
   input  logic                summary_i,
   output int                  tests_failed_o,
   output int                  checks_o
);

   int              test_errs;
   int              tests_passed;
   logic [8*24-1:0] name_q;

   initial begin
      test_errs      = 0;
      tests_passed   = 0;
      tests_failed_o = 0;
      checks_o       = 0;
      name_q         = '0;
   end

   // Sampled mid-cycle, where bus and board outputs are settled.
   always @(negedge wbc_clk_i) begin
      if (test_start_i) begin
         test_errs = 0;
         name_q    = test_name_i;
      end
      // Host read data at ack.
      if (host_rsp_i.ack && rd_chk_i) begin
         checks_o++;
         if (host_rsp_i.dat !== rd_exp_i) begin
            test_errs++;
            $display("mismatch at %0t: read of %h returned %h, expected %h",
                     $time, rd_adr_i, host_rsp_i.dat, rd_exp_i);
         end
      end
      // Board-facing levels.
      if (out_chk_i) begin
         checks_o++;
         if (led_i !== exp_led_i || ice40_reset_i !== exp_ice40_i) begin
            test_errs++;
            $display("mismatch at %0t: led %h ice40 reset %b, expected led %h ice40 reset %b",
                     $time, led_i, ice40_reset_i, exp_led_i, exp_ice40_i);
         end
      end
      if (test_end_i) begin
         if (test_errs == 0 && !fault_i) begin
            tests_passed++;
            $display("test %0s passed", name_q);
         end else begin
            tests_failed_o++;
            $display("test %0s failed with %0d mismatches", name_q, test_errs);
         end
      end
      if (summary_i) begin
         $display("summary: %0d tests passed, %0d tests failed, %0d checks",
                  tests_passed, tests_failed_o, checks_o);
      end
   end

endmodule

/* verification/tb_surf4_ctrl.sv */
`timescale 1ns/1ps

module tb_surf4_ctrl import surf4_pkg::*; ();

   // Board parameters at the RTL top level defaults.
   localparam logic [WB_DAT_W-1:0] BOARD_ID   = 32'h5355_5246;
   localparam logic [WB_DAT_W-1:0] FW_VERSION = 32'h0004_0001;
   localparam int                  HK_DEPTH   = 16;

   localparam int    RST_CYCLES   = 4;
   localparam int    ACK_TIMEOUT  = 200;
   localparam int    NAME_W       = 8*24;
   localparam string PATTERN_FILE = "verification/surf4_ctrl_patterns.txt";

   // DUT ports.
   logic       wbc_clk;
   logic       rst_n;
   wbc_req_t   host_req;
   wbc_rsp_t   host_rsp;
   logic       pps;
   logic       ice40_reset;
   logic [3:0] led;

   // Expected values and strobes for the checker.
   logic                rd_chk;
   logic [WB_DAT_W-1:0] rd_exp;
   logic [WB_ADR_W-1:0] rd_adr;
   logic                out_chk;
   logic [3:0]          exp_led;
   logic                exp_ice40;
   logic                test_start;
   logic                test_end;
   logic [NAME_W-1:0]   test_name;
   logic                fault;
   logic                summary;
   int                  tests_failed;
   int                  checks;

   int   fd;
   int   pps_count_bg;
   int   pps_gap_bg;
   logic timed_out;
   logic file_err;
   logic in_test;

   surf4_ctrl_top #(
      .BOARD_ID  (BOARD_ID),
      .FW_VERSION(FW_VERSION),
      .HK_DEPTH  (HK_DEPTH)
   ) u_surf4_ctrl_top (
      .wbc_clk_i    (wbc_clk),
      .rst_n_i      (rst_n),
      .host_req_i   (host_req),
      .host_rsp_o   (host_rsp),
      .pps_i        (pps),
      .ice40_reset_o(ice40_reset),
      .led_o        (led)
   );

   surf4_ctrl_checker u_checker (
      .wbc_clk_i     (wbc_clk),
      .host_rsp_i    (host_rsp),
      .ice40_reset_i (ice40_reset),
      .led_i         (led),
      .rd_chk_i      (rd_chk),
      .rd_exp_i      (rd_exp),
      .rd_adr_i      (rd_adr),
      .out_chk_i     (out_chk),
      .exp_led_i     (exp_led),
      .exp_ice40_i   (exp_ice40),
      .test_start_i  (test_start),
      .test_end_i    (test_end),
      .test_name_i   (test_name),
      .fault_i       (fault),
      .summary_i     (summary),
      .tests_failed_o(tests_failed),
      .checks_o      (checks)
   );

   // 4 ns clock.
   always #2 wbc_clk = ~wbc_clk;

   // One host transfer with read data compared by the checker at ack.
   task automatic host_transfer(
      input logic                we,
      input logic [WB_ADR_W-1:0] adr,
      input logic [WB_DAT_W-1:0] dat
   );
      int   waited;
      logic got;
      waited = 0;
      got    = 1'b0;
      @(posedge wbc_clk);
      #1;
      host_req.cyc = 1'b1;
      host_req.stb = 1'b1;
      host_req.we  = we;
      host_req.adr = adr;
      host_req.dat = we ? dat : '0;
      host_req.sel = '1;
      rd_chk       = !we;
      rd_exp       = dat;
      rd_adr       = adr;
      // Ack is sampled mid-cycle.
      while (!got && waited < ACK_TIMEOUT) begin
         @(negedge wbc_clk);
         if (host_rsp.ack) begin
            got = 1'b1;
         end else begin
            waited++;
         end
      end
      // Request is held through the ack edge and then released.
      @(posedge wbc_clk);
      #1;
      host_req = '0;
      rd_chk   = 1'b0;
      if (!got) begin
         $display("timeout: no ack on the host port for address %h after %0d cycles",
                  adr, ACK_TIMEOUT);
         fault     = 1'b1;
         timed_out = 1'b1;
      end
   endtask

   // One-cycle PPS pulses with idle cycles between them.
   task automatic pps_burst(input int count, input int gap);
      for (int n = 0; n < count; n++) begin
         @(posedge wbc_clk);
         #1;
         pps = 1'b1;
         @(posedge wbc_clk);
         #1;
         pps = 1'b0;
         repeat (gap) @(posedge wbc_clk);
      end
   endtask

   task automatic check_outputs(input logic [3:0] leds, input logic ice40);
      @(posedge wbc_clk);
      #1;
      exp_led   = leds;
      exp_ice40 = ice40;
      out_chk   = 1'b1;
      @(posedge wbc_clk);
      #1;
      out_chk = 1'b0;
   endtask

   task automatic finish_test();
      @(posedge wbc_clk);
      #1;
      test_end = 1'b1;
      @(posedge wbc_clk);
      #1;
      test_end = 1'b0;
      in_test  = 1'b0;
   endtask

   task automatic start_test(input logic [NAME_W-1:0] name);
      if (in_test) begin
         finish_test();
      end
      @(posedge wbc_clk);
      #1;
      test_name  = name;
      test_start = 1'b1;
      @(posedge wbc_clk);
      #1;
      test_start = 1'b0;
      in_test    = 1'b1;
   endtask

   // Command reader with one command per line.
   task automatic run_patterns();
      logic [8*8-1:0]      op;
      logic [NAME_W-1:0]   name;
      logic [WB_DAT_W-1:0] f1;
      logic [WB_DAT_W-1:0] f2;
      int                  n1;
      int                  n2;
      int                  n3;
      int                  code;
      int                  ch;
      logic                done;
      done = 1'b0;
      while (!done && !timed_out) begin
         code = $fscanf(fd, "%s", op);
         if (code != 1) begin
            done = 1'b1;
         end else if (op == "#") begin
            // Skip the rest of a comment line.
            ch = $fgetc(fd);
            while (ch != "\n" && ch != -1) begin
               ch = $fgetc(fd);
            end
         end else if (op == "TEST") begin
            code = $fscanf(fd, "%s", name);
            start_test(name);
         end else if (op == "WR" || op == "RD" || op == "OUT") begin
            code = $fscanf(fd, "%h %h", f1, f2);
            if (code != 2) begin
               $display("error: missing fields after a %0s command", op);
               file_err = 1'b1;
               done     = 1'b1;
            end else if (op == "WR") begin
               host_transfer(1'b1, f1[WB_ADR_W-1:0], f2);
            end else if (op == "RD") begin
               host_transfer(1'b0, f1[WB_ADR_W-1:0], f2);
            end else begin
               check_outputs(f1[3:0], f2[0]);
            end
         end else if (op == "PPS") begin
            code = $fscanf(fd, "%d %d %d", n1, n2, n3);
            if (code != 3) begin
               $display("error: missing fields after a PPS command");
               file_err = 1'b1;
               done     = 1'b1;
            end else if (n3 != 0) begin
               pps_burst(n1, n2);
            end else begin
               // Background burst beside the running host commands.
               pps_count_bg = n1;
               pps_gap_bg   = n2;
               fork
                  pps_burst(pps_count_bg, pps_gap_bg);
               join_none
            end
         end else begin
            $display("error: unknown pattern command %0s", op);
            file_err = 1'b1;
            done     = 1'b1;
         end
      end
   endtask

   initial begin
      wbc_clk    = 1'b0;
      rst_n      = 1'b0;
      host_req   = '0;
      pps        = 1'b0;
      rd_chk     = 1'b0;
      rd_exp     = '0;
      rd_adr     = '0;
      out_chk    = 1'b0;
      exp_led    = '0;
      exp_ice40  = 1'b0;
      test_start = 1'b0;
      test_end   = 1'b0;
      test_name  = '0;
      fault      = 1'b0;
      summary    = 1'b0;
      timed_out  = 1'b0;
      file_err   = 1'b0;
      in_test    = 1'b0;
      fd = $fopen(PATTERN_FILE, "r");
      if (fd == 0) begin
         $display("error: cannot open the pattern file %0s", PATTERN_FILE);
         file_err = 1'b1;
      end
      repeat (RST_CYCLES) @(posedge wbc_clk);
      #1;
      rst_n = 1'b1;
      if (!file_err) begin
         run_patterns();
         $fclose(fd);
      end
      if (in_test) begin
         finish_test();
      end
      @(posedge wbc_clk);
      #1;
      summary = 1'b1;
      @(posedge wbc_clk);
      #1;
      summary = 1'b0;
      if (file_err || timed_out || tests_failed != 0 || checks == 0) begin
         $display("TESTBENCH FAILED");
      end else begin
         $display("TESTBENCH PASSED");
      end
      $finish;
   end

endmodule

/* verification/surf4_ctrl_patterns.txt */
# Columns: TEST name | WR addr data | RD addr expected | OUT leds ice40_reset (hex)
# PPS count gap wait, in decimal; wait 0 runs the burst beside the host commands.
TEST reset_values
RD 00000 53555246
RD 00004 00040001
RD 00008 00000001
RD 10000 00000000
RD 10004 00000000
OUT 0 1
TEST registers
WR 0000C 12345678
RD 0000C 12345678
WR 00008 000000A0
RD 00008 000000A0
OUT A 0
WR 00000 FFFFFFFF
RD 00000 53555246
TEST housekeeping
WR 10004 00000001
RD 10004 00000001
PPS 3 40 1
RD 10000 00000003
RD 20004 00000001
RD 20008 00000002
RD 2000C 00000003
TEST contention
PPS 1 0 0
RD 20004 00000001
RD 20008 00000002
RD 2000C 00000003
RD 20004 00000001
RD 20008 00000002
RD 2000C 00000003
RD 10000 00000004
RD 20010 00000004
TEST wrap_and_unmapped
PPS 13 40 1
RD 10000 00000011
RD 20004 00000011
RD 20000 00000010
RD 30000 00000000
WR 3000C DEADBEEF
RD 3000C 00000000
RD 0000C 12345678
RD 20000 00000010

/* tb.f */
src/surf4_pkg.sv
src/wbc_intercon.sv
src/surf4_id_ctrl.sv
src/surf4_hk_collector.sv
src/hk_buffer.sv
src/surf4_ctrl_top.sv
verification/surf4_ctrl_checker.sv
verification/tb_surf4_ctrl.sv

/* Makefile */
# Verilator build and run of the SURF4 control bus testbench.

VERILATOR ?= verilator
TOP       ?= tb_surf4_ctrl
LOG       ?= sim.log
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The simulation result is taken from the log.
run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "TESTBENCH PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
